// ==== source/saturn_alu_pkg.sv ====
// shared types for the nibble-serial ALU core, used by the RTL and the testbench via scoped names
package saturn_alu_pkg;

  // nibbles per working register, fixed by the architecture
  localparam int NIBBLES = 16;

  // one hex digit, the unit the ALU computes on
  typedef logic [3:0] nibble_t;

  // nibble position inside a register
  typedef logic [$clog2(NIBBLES)-1:0] field_idx_t;

  // whole working register, nibble 0 in the low bits
  typedef logic [4*NIBBLES-1:0] word_t;

  // register selectors, IMM and ZERO only make sense as sources
  typedef enum logic [2:0] {
    REG_A    = 3'd0,
    REG_B    = 3'd1,
    REG_C    = 3'd2,
    REG_D    = 3'd3,
    REG_R0   = 3'd4,
    REG_R1   = 3'd5,
    REG_IMM  = 3'd6,
    REG_ZERO = 3'd7
  } reg_id_e;

  typedef enum logic [2:0] {
    OP_ZERO     = 3'd0,
    OP_COPY     = 3'd1,
    OP_EXCH     = 3'd2,
    OP_ADD      = 3'd3,
    OP_DEC      = 3'd4,
    OP_2CMPL    = 3'd5,
    OP_CLR_MASK = 3'd6,
    OP_TEST_NEQ = 3'd7
  } alu_op_e;

  // command as handed over by the requester
  typedef struct packed {
    alu_op_e    op;
    reg_id_e    dest;
    reg_id_e    src1;
    reg_id_e    src2;
    field_idx_t field_first;
    field_idx_t field_last;
    nibble_t    imm;
  } alu_cmd_t;

  // per-cycle phase strobes from the sequencer
  typedef struct packed {
    logic       prep;
    logic       calc;
    logic       save;
    logic       first;
    logic       last;
    logic       clear;
    field_idx_t idx;
  } alu_step_t;

  // save request, port 2 is only used by exchange
  typedef struct packed {
    logic       we1;
    reg_id_e    reg1;
    nibble_t    data1;
    logic       we2;
    reg_id_e    reg2;
    nibble_t    data2;
    field_idx_t idx;
  } nib_write_t;

endpackage

// ==== source/alu_field_sequencer.sv ====
// command latch and phase FSM, sweeps the registers clear after reset and walks each field
`timescale 1ns/1ps

module alu_field_sequencer (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_cmd_valid,
  input  saturn_alu_pkg::alu_cmd_t   i_cmd,
  output logic                       o_busy,
  output logic                       o_done,
  output saturn_alu_pkg::alu_cmd_t   o_cmd,
  output saturn_alu_pkg::alu_step_t  o_step
);

  typedef enum logic [2:0] {
    IDLE,
    CLEAR,
    PREP,
    CALC,
    SAVE,
    DONE
  } phase_e;

  localparam saturn_alu_pkg::field_idx_t LAST_IDX =
    saturn_alu_pkg::field_idx_t'(saturn_alu_pkg::NIBBLES - 1);

  phase_e                      state;
  saturn_alu_pkg::field_idx_t  idx;
  saturn_alu_pkg::alu_cmd_t    cmd_q;
  logic                        accept;

  // a new command may land in the DONE cycle, busy is already low there
  assign o_busy = (state != IDLE) && (state != DONE);
  assign o_done = (state == DONE);
  assign accept = i_cmd_valid && !o_busy;
  assign o_cmd  = cmd_q;

  always_comb begin
    o_step.prep  = (state == PREP);
    o_step.calc  = (state == CALC);
    o_step.save  = (state == SAVE);
    o_step.first = (idx == cmd_q.field_first);
    o_step.last  = (idx == cmd_q.field_last);
    o_step.clear = (state == CLEAR);
    o_step.idx   = idx;
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      cmd_q <= i_cmd;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= CLEAR;
      idx   <= '0;
    end else begin
      case (state)
        CLEAR: begin
          // idx wraps back to 0 as the sweep ends
          idx <= idx + 1'b1;
          if (idx == LAST_IDX) begin
            state <= IDLE;
          end
        end
        IDLE, DONE: begin
          if (accept) begin
            state <= PREP;
            idx   <= i_cmd.field_first;
          end else begin
            state <= IDLE;
          end
        end
        PREP: state <= CALC;
        CALC: state <= SAVE;
        SAVE: begin
          if (o_step.last) begin
            state <= DONE;
          end else begin
            // fields may wrap from nibble 15 to nibble 0
            state <= PREP;
            idx   <= idx + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // the datapath relies on seeing at most one phase strobe per cycle
  a_single_phase: assert property (@(posedge i_clk) disable iff (i_reset)
    $onehot0({o_step.prep, o_step.calc, o_step.save}));

endmodule

// ==== source/alu_nibble_datapath.sv ====
// operand fetch, nibble arithmetic with carry chain and the carry flag, one nibble per phase triple
`timescale 1ns/1ps

module alu_nibble_datapath (
  input  logic                        i_clk,
  input  logic                        i_reset,
  input  saturn_alu_pkg::alu_cmd_t    i_cmd,
  input  saturn_alu_pkg::alu_step_t   i_step,
  output saturn_alu_pkg::reg_id_e     o_rd_sel1,
  output saturn_alu_pkg::reg_id_e     o_rd_sel2,
  input  saturn_alu_pkg::nibble_t     i_rd_nib1,
  input  saturn_alu_pkg::nibble_t     i_rd_nib2,
  output saturn_alu_pkg::nib_write_t  o_wr,
  output logic                        o_carry
);

  // prepared operands
  saturn_alu_pkg::nibble_t  p_src1;
  saturn_alu_pkg::nibble_t  p_src2;
  logic                     p_carry;

  // calculated results
  saturn_alu_pkg::nibble_t  c_res1;
  saturn_alu_pkg::nibble_t  c_res2;
  logic                     c_carry;
  logic                     res_nz;

  saturn_alu_pkg::nibble_t  calc_res1;
  saturn_alu_pkg::nibble_t  calc_res2;
  logic                     calc_carry;
  logic                     carry_q;

  function automatic saturn_alu_pkg::nibble_t pick_src(
    input saturn_alu_pkg::reg_id_e sel,
    input saturn_alu_pkg::nibble_t rd,
    input saturn_alu_pkg::nibble_t imm
  );
    case (sel)
      saturn_alu_pkg::REG_IMM:  return imm;
      saturn_alu_pkg::REG_ZERO: return '0;
      default:                  return rd;
    endcase
  endfunction

  assign o_rd_sel1 = i_cmd.src1;
  assign o_rd_sel2 = i_cmd.src2;
  assign o_carry   = carry_q;

  always_ff @(posedge i_clk) begin
    if (i_step.prep) begin
      p_src1 <= pick_src(i_cmd.src1, i_rd_nib1, i_cmd.imm);
      p_src2 <= pick_src(i_cmd.src2, i_rd_nib2, i_cmd.imm);
      // negation starts with +1, everything else chains from zero
      if (i_step.first) begin
        p_carry <= (i_cmd.op == saturn_alu_pkg::OP_2CMPL);
      end else begin
        p_carry <= c_carry;
      end
    end
  end

  always_comb begin
    calc_res1  = p_src1;
    calc_res2  = p_src2;
    calc_carry = p_carry;
    case (i_cmd.op)
      saturn_alu_pkg::OP_ZERO: calc_res1 = '0;
      saturn_alu_pkg::OP_EXCH: begin
        calc_res1 = p_src2;
        calc_res2 = p_src1;
      end
      saturn_alu_pkg::OP_ADD: begin
        {calc_carry, calc_res1} = 5'(p_src1) + 5'(p_src2) + 5'(p_carry);
      end
      // adding F is minus one, carry out means no borrow
      saturn_alu_pkg::OP_DEC: begin
        {calc_carry, calc_res1} = 5'(p_src1) + 5'hF + 5'(p_carry);
      end
      saturn_alu_pkg::OP_2CMPL: begin
        calc_res1  = ~p_src1 + {3'b000, p_carry};
        calc_carry = (p_src1 == '0) && p_carry;
      end
      saturn_alu_pkg::OP_CLR_MASK: calc_res1 = p_src1 & ~p_src2;
      saturn_alu_pkg::OP_TEST_NEQ: calc_carry = (p_src1 != p_src2) || p_carry;
      default: calc_res1 = p_src1;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_step.calc) begin
      c_res1  <= calc_res1;
      c_res2  <= calc_res2;
      c_carry <= calc_carry;
      res_nz  <= (i_step.first ? 1'b0 : res_nz) | (calc_res1 != '0);
    end
  end

  always_comb begin
    o_wr.we1   = 1'b0;
    o_wr.reg1  = i_cmd.dest;
    o_wr.data1 = c_res1;
    o_wr.we2   = 1'b0;
    o_wr.reg2  = i_cmd.src2;
    o_wr.data2 = c_res2;
    o_wr.idx   = i_step.idx;
    case (i_cmd.op)
      saturn_alu_pkg::OP_EXCH: begin
        // both sources get written back swapped
        o_wr.we1  = i_step.save;
        o_wr.reg1 = i_cmd.src1;
        o_wr.we2  = i_step.save;
      end
      saturn_alu_pkg::OP_TEST_NEQ: o_wr.we1 = 1'b0;
      default: o_wr.we1 = i_step.save;
    endcase
  end

  // carry flag only moves on the final save of a field
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      carry_q <= 1'b0;
    end else if (i_step.save && i_step.last) begin
      case (i_cmd.op)
        saturn_alu_pkg::OP_ADD,
        saturn_alu_pkg::OP_DEC,
        saturn_alu_pkg::OP_TEST_NEQ: carry_q <= c_carry;
        saturn_alu_pkg::OP_2CMPL:    carry_q <= res_nz;
        default:                     carry_q <= carry_q;
      endcase
    end
  end

  // a command must never target a pseudo register
  a_wr1_real_reg: assert property (@(posedge i_clk) disable iff (i_reset)
    o_wr.we1 |-> (o_wr.reg1 != saturn_alu_pkg::REG_IMM &&
                  o_wr.reg1 != saturn_alu_pkg::REG_ZERO));
  a_wr2_real_reg: assert property (@(posedge i_clk) disable iff (i_reset)
    o_wr.we2 |-> (o_wr.reg2 != saturn_alu_pkg::REG_IMM &&
                  o_wr.reg2 != saturn_alu_pkg::REG_ZERO));

endmodule

// ==== source/alu_work_regs.sv ====
// six nibble-addressed working registers with two read ports, a save port, clear sweep and peek
`timescale 1ns/1ps

module alu_work_regs (
  input  logic                        i_clk,
  input  saturn_alu_pkg::alu_step_t   i_step,
  input  saturn_alu_pkg::reg_id_e     i_rd_sel1,
  input  saturn_alu_pkg::reg_id_e     i_rd_sel2,
  output saturn_alu_pkg::nibble_t     o_rd_nib1,
  output saturn_alu_pkg::nibble_t     o_rd_nib2,
  input  saturn_alu_pkg::nib_write_t  i_wr,
  input  saturn_alu_pkg::reg_id_e     i_peek_reg,
  output saturn_alu_pkg::word_t       o_peek_word
);

  // A, B, C, D, R0, R1 in reg id order
  localparam int NUM_REGS = 6;

  saturn_alu_pkg::nibble_t regs [NUM_REGS][saturn_alu_pkg::NIBBLES];

  function automatic logic is_reg(input saturn_alu_pkg::reg_id_e sel);
    return (int'(sel) < NUM_REGS);
  endfunction

  // pseudo registers read back as zero
  function automatic saturn_alu_pkg::nibble_t read_nib(
    input saturn_alu_pkg::reg_id_e    sel,
    input saturn_alu_pkg::field_idx_t idx
  );
    if (is_reg(sel)) begin
      return regs[sel][idx];
    end
    return '0;
  endfunction

  assign o_rd_nib1 = read_nib(i_rd_sel1, i_step.idx);
  assign o_rd_nib2 = read_nib(i_rd_sel2, i_step.idx);

  always_comb begin
    for (int n = 0; n < saturn_alu_pkg::NIBBLES; n++) begin
      o_peek_word[n*4 +: 4] = read_nib(i_peek_reg, saturn_alu_pkg::field_idx_t'(n));
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_step.clear) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r][i_step.idx] <= '0;
      end
    end else begin
      if (i_wr.we1 && is_reg(i_wr.reg1)) begin
        regs[i_wr.reg1][i_wr.idx] <= i_wr.data1;
      end
      // exchange of a register with itself writes the same nibble twice
      if (i_wr.we2 && is_reg(i_wr.reg2)) begin
        regs[i_wr.reg2][i_wr.idx] <= i_wr.data2;
      end
    end
  end

  // the datapath must stay quiet while the sequencer sweeps
  a_no_save_in_clear: assert property (@(posedge i_clk)
    i_step.clear |-> !(i_wr.we1 || i_wr.we2));

endmodule

// ==== source/saturn_alu_core.sv ====
// top level of the nibble-serial ALU, takes commands over valid/busy and exposes a register peek
`timescale 1ns/1ps

module saturn_alu_core (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_cmd_valid,
  input  saturn_alu_pkg::alu_cmd_t   i_cmd,
  output logic                       o_busy,
  output logic                       o_done,
  output logic                       o_carry,
  input  saturn_alu_pkg::reg_id_e    i_peek_reg,
  output saturn_alu_pkg::word_t      o_peek_word
);

  saturn_alu_pkg::alu_cmd_t    cmd_q;
  saturn_alu_pkg::alu_step_t   step;
  saturn_alu_pkg::reg_id_e     rd_sel1;
  saturn_alu_pkg::reg_id_e     rd_sel2;
  saturn_alu_pkg::nibble_t     rd_nib1;
  saturn_alu_pkg::nibble_t     rd_nib2;
  saturn_alu_pkg::nib_write_t  wr;

  alu_field_sequencer u_seq (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd       (i_cmd),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_cmd       (cmd_q),
    .o_step      (step)
  );

  alu_nibble_datapath u_dp (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_cmd     (cmd_q),
    .i_step    (step),
    .o_rd_sel1 (rd_sel1),
    .o_rd_sel2 (rd_sel2),
    .i_rd_nib1 (rd_nib1),
    .i_rd_nib2 (rd_nib2),
    .o_wr      (wr),
    .o_carry   (o_carry)
  );

  alu_work_regs u_regs (
    .i_clk       (i_clk),
    .i_step      (step),
    .i_rd_sel1   (rd_sel1),
    .i_rd_sel2   (rd_sel2),
    .o_rd_nib1   (rd_nib1),
    .o_rd_nib2   (rd_nib2),
    .i_wr        (wr),
    .i_peek_reg  (i_peek_reg),
    .o_peek_word (o_peek_word)
  );

endmodule

// ==== verif/saturn_alu_tb.sv ====
// simulation top that drives saturn_alu_core with directed field operations against a word model
`timescale 1ns/1ps

module saturn_alu_tb;

  localparam int          SWEEP_TIMEOUT = 64;
  localparam int          IDLE_TIMEOUT  = 200;
  localparam int          DONE_TIMEOUT  = 200;
  localparam int          NUM_REGS      = 6;
  localparam logic [31:0] LFSR_SEED     = 32'h02115753;
  localparam logic [31:0] LFSR_TAPS     = 32'hA3000000;

  logic                      i_clk;
  logic                      i_reset;
  logic                      i_cmd_valid;
  saturn_alu_pkg::alu_cmd_t  i_cmd;
  logic                      o_busy;
  logic                      o_done;
  logic                      o_carry;
  saturn_alu_pkg::reg_id_e   i_peek_reg;
  saturn_alu_pkg::word_t     o_peek_word;

  // expected register contents in reg id order from A to R1
  saturn_alu_pkg::word_t     model [NUM_REGS];
  logic                      model_carry;
  logic [31:0]               lfsr;
  int                        errors;
  int                        timeouts;

  saturn_alu_core dut (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd       (i_cmd),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_carry     (o_carry),
    .i_peek_reg  (i_peek_reg),
    .o_peek_word (o_peek_word)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // galois form stepped once per bit handed out
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = {1'b0, lfsr[31:1]} ^ (out ? LFSR_TAPS : 32'h0);
    return out;
  endfunction

  function automatic saturn_alu_pkg::nibble_t rand_nibble();
    saturn_alu_pkg::nibble_t v;
    for (int b = 0; b < 4; b++) begin
      v[b] = lfsr_bit();
    end
    return v;
  endfunction

  function automatic saturn_alu_pkg::alu_cmd_t make_cmd(
    input saturn_alu_pkg::alu_op_e op, input saturn_alu_pkg::reg_id_e dest,
    input saturn_alu_pkg::reg_id_e src1, input saturn_alu_pkg::reg_id_e src2,
    input int first, input int last, input saturn_alu_pkg::nibble_t imm);
    return '{op, dest, src1, src2, saturn_alu_pkg::field_idx_t'(first),
             saturn_alu_pkg::field_idx_t'(last), imm};
  endfunction

  // field length wraps from nibble 15 to nibble 0
  function automatic int field_len(input saturn_alu_pkg::alu_cmd_t c);
    return ((int'(c.field_last) - int'(c.field_first)) & 15) + 1;
  endfunction

  // field nibbles gathered into the low end of a word
  function automatic saturn_alu_pkg::word_t get_field(
    input saturn_alu_pkg::word_t w, input int first, input int n);
    saturn_alu_pkg::word_t r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r[4*k +: 4] = w[4*((first + k) % 16) +: 4];
    end
    return r;
  endfunction

  function automatic saturn_alu_pkg::word_t put_field(
    input saturn_alu_pkg::word_t w, input int first, input int n,
    input saturn_alu_pkg::word_t v);
    saturn_alu_pkg::word_t r;
    r = w;
    for (int k = 0; k < n; k++) begin
      r[4*((first + k) % 16) +: 4] = v[4*k +: 4];
    end
    return r;
  endfunction

  function automatic saturn_alu_pkg::word_t src_field(
    input saturn_alu_pkg::reg_id_e sel, input saturn_alu_pkg::nibble_t imm,
    input int first, input int n);
    saturn_alu_pkg::word_t r;
    r = '0;
    if (sel == saturn_alu_pkg::REG_IMM) begin
      for (int k = 0; k < n; k++) begin
        r[4*k +: 4] = imm;
      end
    end else if (sel != saturn_alu_pkg::REG_ZERO) begin
      r = get_field(model[int'(sel)], first, n);
    end
    return r;
  endfunction

  // field semantics applied to whole field values
  task automatic apply_model(input saturn_alu_pkg::alu_cmd_t c);
    int                    first;
    int                    n;
    int                    d;
    saturn_alu_pkg::word_t a;
    saturn_alu_pkg::word_t b;
    saturn_alu_pkg::word_t mask;
    logic [64:0]           sum;
    first = int'(c.field_first);
    n     = field_len(c);
    d     = int'(c.dest);
    a     = src_field(c.src1, c.imm, first, n);
    b     = src_field(c.src2, c.imm, first, n);
    mask  = saturn_alu_pkg::word_t'((65'd1 << (4 * n)) - 65'd1);
    case (c.op)
      saturn_alu_pkg::OP_ZERO: model[d] = put_field(model[d], first, n, '0);
      saturn_alu_pkg::OP_COPY: model[d] = put_field(model[d], first, n, a);
      saturn_alu_pkg::OP_EXCH: begin
        model[int'(c.src1)] = put_field(model[int'(c.src1)], first, n, b);
        model[int'(c.src2)] = put_field(model[int'(c.src2)], first, n, a);
      end
      saturn_alu_pkg::OP_ADD: begin
        sum         = {1'b0, a} + {1'b0, b};
        model[d]    = put_field(model[d], first, n, sum[63:0]);
        model_carry = sum[4*n];
      end
      saturn_alu_pkg::OP_DEC: begin
        model[d]    = put_field(model[d], first, n, a - 64'd1);
        model_carry = (a != '0);
      end
      saturn_alu_pkg::OP_2CMPL: begin
        model[d]    = put_field(model[d], first, n, (64'd0 - a) & mask);
        model_carry = (((64'd0 - a) & mask) != '0);
      end
      saturn_alu_pkg::OP_CLR_MASK: model[d] = put_field(model[d], first, n, a & ~b);
      default: model_carry = (a != b);
    endcase
  endtask

  task automatic check_word(input saturn_alu_pkg::word_t got, input saturn_alu_pkg::word_t exp,
                            input string name);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_carry(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t o_carry got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_cycles(input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t o_done latency got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks done with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timed out waiting for %s", what);
    finish_run();
  endtask

  task automatic check_reg(input int r);
    @(negedge i_clk);
    i_peek_reg = saturn_alu_pkg::reg_id_e'(r);
    #1;
    check_word(o_peek_word, model[r], $sformatf("o_peek_word(%s)", i_peek_reg.name()));
  endtask

  task automatic check_all_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      check_reg(r);
    end
  endtask

  // called on a falling edge and returns on the first falling edge with busy low
  task automatic wait_idle(input int limit);
    int waited;
    waited = 0;
    while (o_busy) begin
      if (waited >= limit)
        report_timeout("o_busy to fall");
      @(negedge i_clk);
      waited++;
    end
  endtask

  task automatic start_cmd(input saturn_alu_pkg::alu_cmd_t c, input logic keep_valid);
    @(negedge i_clk);
    wait_idle(IDLE_TIMEOUT);
    i_cmd       = c;
    i_cmd_valid = 1'b1;
    // acceptance edge passes here
    @(negedge i_clk);
    i_cmd_valid = keep_valid;
  endtask

  // counts cycles after the acceptance edge starting in cycle 1
  task automatic wait_done(output int cycles);
    cycles = 1;
    while (!o_done) begin
      if (cycles >= DONE_TIMEOUT)
        report_timeout("o_done");
      @(negedge i_clk);
      cycles++;
    end
  endtask

  task automatic finish_cmd(input saturn_alu_pkg::alu_cmd_t c, input int cycles);
    check_cycles(cycles, 3 * field_len(c) + 1);
    apply_model(c);
    check_carry(o_carry, model_carry);
  endtask

  task automatic run_cmd(input saturn_alu_pkg::alu_cmd_t c);
    int cycles;
    start_cmd(c, 1'b0);
    wait_done(cycles);
    finish_cmd(c, cycles);
  endtask

  task automatic test_after_reset();
    if (o_busy !== 1'b1) begin
      errors++;
      $display("o_busy was low right after reset instead of sweeping");
    end
    wait_idle(SWEEP_TIMEOUT);
    for (int r = 0; r < NUM_REGS; r++) begin
      model[r] = '0;
    end
    model_carry = 1'b0;
    check_all_regs();
    check_carry(o_carry, 1'b0);
  endtask

  task automatic test_load_copy();
    for (int r = 0; r < NUM_REGS; r++) begin
      for (int i = 0; i < 16; i++) begin
        run_cmd(make_cmd(saturn_alu_pkg::OP_COPY, saturn_alu_pkg::reg_id_e'(r),
                         saturn_alu_pkg::REG_IMM, saturn_alu_pkg::REG_ZERO, i, i, rand_nibble()));
      end
    end
    check_all_regs();
    run_cmd(make_cmd(saturn_alu_pkg::OP_COPY, saturn_alu_pkg::REG_C, saturn_alu_pkg::REG_A,
                     saturn_alu_pkg::REG_ZERO, 3, 9, 4'h0));
    // field wraps through nibble 15
    run_cmd(make_cmd(saturn_alu_pkg::OP_EXCH, saturn_alu_pkg::REG_A, saturn_alu_pkg::REG_B,
                     saturn_alu_pkg::REG_D, 14, 2, 4'h0));
    check_all_regs();
  endtask

  task automatic test_add_dec();
    run_cmd(make_cmd(saturn_alu_pkg::OP_ADD, saturn_alu_pkg::REG_C, saturn_alu_pkg::REG_A,
                     saturn_alu_pkg::REG_B, 0, 15, 4'h0));
    run_cmd(make_cmd(saturn_alu_pkg::OP_ADD, saturn_alu_pkg::REG_D, saturn_alu_pkg::REG_C,
                     saturn_alu_pkg::REG_R0, 4, 7, 4'h0));
    run_cmd(make_cmd(saturn_alu_pkg::OP_COPY, saturn_alu_pkg::REG_R0, saturn_alu_pkg::REG_IMM,
                     saturn_alu_pkg::REG_ZERO, 0, 3, 4'hF));
    // FFFF plus 1111 must overflow
    run_cmd(make_cmd(saturn_alu_pkg::OP_ADD, saturn_alu_pkg::REG_R0, saturn_alu_pkg::REG_R0,
                     saturn_alu_pkg::REG_IMM, 0, 3, 4'h1));
    check_carry(o_carry, 1'b1);
    run_cmd(make_cmd(saturn_alu_pkg::OP_ZERO, saturn_alu_pkg::REG_D, saturn_alu_pkg::REG_ZERO,
                     saturn_alu_pkg::REG_ZERO, 5, 8, 4'h0));
    run_cmd(make_cmd(saturn_alu_pkg::OP_DEC, saturn_alu_pkg::REG_D, saturn_alu_pkg::REG_D,
                     saturn_alu_pkg::REG_ZERO, 5, 8, 4'h0));
    check_carry(o_carry, 1'b0);
    check_reg(int'(saturn_alu_pkg::REG_D));
    check_word(get_field(o_peek_word, 5, 4), 64'hFFFF, "o_peek_word(REG_D) nibbles 5..8");
    run_cmd(make_cmd(saturn_alu_pkg::OP_COPY, saturn_alu_pkg::REG_C, saturn_alu_pkg::REG_IMM,
                     saturn_alu_pkg::REG_ZERO, 0, 3, 4'h3));
    run_cmd(make_cmd(saturn_alu_pkg::OP_DEC, saturn_alu_pkg::REG_C, saturn_alu_pkg::REG_C,
                     saturn_alu_pkg::REG_ZERO, 0, 3, 4'h0));
    check_carry(o_carry, 1'b1);
    check_all_regs();
  endtask

  task automatic test_negate_mask();
    run_cmd(make_cmd(saturn_alu_pkg::OP_2CMPL, saturn_alu_pkg::REG_B, saturn_alu_pkg::REG_A,
                     saturn_alu_pkg::REG_ZERO, 2, 11, 4'h0));
    run_cmd(make_cmd(saturn_alu_pkg::OP_ZERO, saturn_alu_pkg::REG_R1, saturn_alu_pkg::REG_ZERO,
                     saturn_alu_pkg::REG_ZERO, 6, 9, 4'h0));
    // negating zero leaves zero and clears carry
    run_cmd(make_cmd(saturn_alu_pkg::OP_2CMPL, saturn_alu_pkg::REG_R1, saturn_alu_pkg::REG_R1,
                     saturn_alu_pkg::REG_ZERO, 6, 9, 4'h0));
    check_carry(o_carry, 1'b0);
    run_cmd(make_cmd(saturn_alu_pkg::OP_CLR_MASK, saturn_alu_pkg::REG_C, saturn_alu_pkg::REG_A,
                     saturn_alu_pkg::REG_B, 0, 15, 4'h0));
    check_all_regs();
  endtask

  task automatic test_not_equal();
    saturn_alu_pkg::nibble_t flip;
    run_cmd(make_cmd(saturn_alu_pkg::OP_COPY, saturn_alu_pkg::REG_R1, saturn_alu_pkg::REG_A,
                     saturn_alu_pkg::REG_ZERO, 0, 15, 4'h0));
    // dest is neither source so a stray write would show up in D
    run_cmd(make_cmd(saturn_alu_pkg::OP_TEST_NEQ, saturn_alu_pkg::REG_D, saturn_alu_pkg::REG_A,
                     saturn_alu_pkg::REG_R1, 0, 15, 4'h0));
    check_carry(o_carry, 1'b0);
    // R1 differs from A only in nibble 7
    flip = model[0][31:28] ^ 4'h1;
    run_cmd(make_cmd(saturn_alu_pkg::OP_COPY, saturn_alu_pkg::REG_R1, saturn_alu_pkg::REG_IMM,
                     saturn_alu_pkg::REG_ZERO, 7, 7, flip));
    run_cmd(make_cmd(saturn_alu_pkg::OP_TEST_NEQ, saturn_alu_pkg::REG_D, saturn_alu_pkg::REG_A,
                     saturn_alu_pkg::REG_R1, 0, 15, 4'h0));
    check_carry(o_carry, 1'b1);
    run_cmd(make_cmd(saturn_alu_pkg::OP_TEST_NEQ, saturn_alu_pkg::REG_D, saturn_alu_pkg::REG_A,
                     saturn_alu_pkg::REG_R1, 0, 6, 4'h0));
    check_carry(o_carry, 1'b0);
    check_all_regs();
  endtask

  task automatic test_back_pressure();
    saturn_alu_pkg::alu_cmd_t first_cmd;
    saturn_alu_pkg::alu_cmd_t second_cmd;
    int                       cycles;
    first_cmd  = make_cmd(saturn_alu_pkg::OP_ADD, saturn_alu_pkg::REG_C, saturn_alu_pkg::REG_A,
                          saturn_alu_pkg::REG_B, 0, 7, 4'h0);
    second_cmd = make_cmd(saturn_alu_pkg::OP_COPY, saturn_alu_pkg::REG_D, saturn_alu_pkg::REG_C,
                          saturn_alu_pkg::REG_ZERO, 0, 15, 4'h0);
    start_cmd(first_cmd, 1'b1);
    // second command stays valid while the first one runs
    i_cmd = second_cmd;
    wait_done(cycles);
    finish_cmd(first_cmd, cycles);
    @(negedge i_clk);
    i_cmd_valid = 1'b0;
    if (o_busy !== 1'b1) begin
      errors++;
      $display("second command was not taken on the edge that ended o_done");
    end
    wait_done(cycles);
    finish_cmd(second_cmd, cycles);
    check_all_regs();
  endtask

  initial begin
    lfsr        = LFSR_SEED;
    errors      = 0;
    timeouts    = 0;
    model_carry = 1'b0;
    i_reset     = 1'b1;
    i_cmd_valid = 1'b0;
    i_cmd       = '0;
    i_peek_reg  = saturn_alu_pkg::REG_A;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;
    test_after_reset();
    test_load_copy();
    test_add_dec();
    test_negate_mask();
    test_not_equal();
    test_back_pressure();
    finish_run();
  end

endmodule

// ==== all.f ====
source/saturn_alu_pkg.sv
source/alu_field_sequencer.sv
source/alu_nibble_datapath.sv
source/alu_work_regs.sv
source/saturn_alu_core.sv
verif/saturn_alu_tb.sv

// ==== Makefile ====
# Verilator flow for the nibble-serial ALU testbench
# every variable below can be overridden on the command line

VERILATOR   ?= verilator
TOP         ?= saturn_alu_tb
FILELIST    ?= all.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= TEST RESULT: PASS
VFLAGS      ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the grep decides pass or fail, so a crash or a failing run exits nonzero
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_STRING)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
